//--- hdl/issue_pkg.sv
// Shared widths, tags, opcodes and bundle types of the out-of-order issue block.
// Compile this first. Every other file refers to it by scoped names.
package issue_pkg;

  // ========================================
  // Sizes
  // ========================================
  localparam int PREG_NUM  = 32;
  localparam int ROB_DEPTH = 16;
  localparam int DATA_W    = 32;

  typedef logic [$clog2(PREG_NUM)-1:0]  preg_t;
  typedef logic [$clog2(ROB_DEPTH)-1:0] rob_idx_t;
  typedef logic [DATA_W-1:0]            data_t;
  typedef logic [1:0]                   alu_op_t;

  // ALU opcodes
  localparam alu_op_t OP_ADD = 2'd0;
  localparam alu_op_t OP_SUB = 2'd1;
  localparam alu_op_t OP_AND = 2'd2;
  localparam alu_op_t OP_XOR = 2'd3;

  // ========================================
  // Bundles
  // ========================================
  // Renamed micro-op as it arrives from dispatch
  typedef struct packed {
    alu_op_t  op;
    rob_idx_t rob_idx;
    logic     age_bit;
    preg_t    pdest;
    preg_t    psrc0;
    logic     psrc0_valid;
    logic     psrc0_ready;
    preg_t    psrc1;
    logic     psrc1_valid;
    logic     psrc1_ready;
  } dispatch_t;

  typedef struct packed {
    logic      valid;
    logic      issued;
    dispatch_t uop;
  } rs_entry_t;

  // Source valid bits travel along so the ALU can zero unused operands
  typedef struct packed {
    alu_op_t  op;
    rob_idx_t rob_idx;
    preg_t    pdest;
    preg_t    psrc0;
    logic     psrc0_valid;
    preg_t    psrc1;
    logic     psrc1_valid;
  } issue_t;

  typedef struct packed {
    logic  valid;
    preg_t pdest;
    data_t data;
  } wb_t;

  typedef struct packed {
    rob_idx_t rob_idx;
    preg_t    pdest;
    data_t    data;
  } result_t;

endpackage

//--- hdl/phys_regfile.sv
// Physical register file shared by all ALUs.
// Every wakeup lane writes on the clock edge; on a tag collision the
// higher lane wins. Each bank gets two combinational read ports.
`timescale 1ns/10ps

module phys_regfile #(
  parameter int BANK_NUM = 2,
  parameter int WB_NUM   = 3
) (
  input  logic                                  clk,
  input  logic                                  rst_n,
  input  issue_pkg::wb_t   [WB_NUM-1:0]         wb_i,
  input  issue_pkg::preg_t [BANK_NUM-1:0][1:0]  rd_addr_i,
  output issue_pkg::data_t [BANK_NUM-1:0][1:0]  rd_data_o
);

  issue_pkg::data_t [issue_pkg::PREG_NUM-1:0] regs_q;

  // ========================================
  // Write ports
  // ========================================
  // Later lanes in the loop override earlier ones to the same register
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      regs_q <= '0;
    end else begin
      for (int l = 0; l < WB_NUM; l++) begin
        if (wb_i[l].valid) begin
          regs_q[wb_i[l].pdest] <= wb_i[l].data;
        end
      end
    end
  end

  // ========================================
  // Read ports
  // ========================================
  always_comb begin
    for (int b = 0; b < BANK_NUM; b++) begin
      for (int p = 0; p < 2; p++) begin
        rd_data_o[b][p] = regs_q[rd_addr_i[b][p]];
      end
    end
  end

endmodule

//--- hdl/rs_bank.sv
// One bank of the non-compacting reservation station.
// Dispatch fills the lowest free slot, writeback lanes wake up sources and
// the oldest ready entry goes to the bank's ALU. An issued slot is reusable
// from the cycle after the issue handshake.
`timescale 1ns/10ps

module rs_bank #(
  parameter int BANK_SIZE = 4,
  parameter int WB_NUM    = 3
) (
  input  logic                               clk,
  input  logic                               rst_n,
  input  logic                               flush_i,
  input  logic                               disp_valid_i,
  input  issue_pkg::dispatch_t               disp_i,
  output logic                               disp_ready_o,
  input  issue_pkg::wb_t [WB_NUM-1:0]        wb_i,
  input  logic                               iss_ready_i,
  output logic                               iss_valid_o,
  output issue_pkg::issue_t                  iss_o
);

  localparam int SLOT_W = (BANK_SIZE > 1) ? $clog2(BANK_SIZE) : 1;

  issue_pkg::rs_entry_t [BANK_SIZE-1:0] ent_q;
  issue_pkg::rs_entry_t [BANK_SIZE-1:0] ent_d;

  logic [BANK_SIZE-1:0] free;
  logic [BANK_SIZE-1:0] rdy;
  logic [SLOT_W-1:0]    wr_idx;
  logic [SLOT_W-1:0]    sel_idx;
  logic                 sel_found;
  issue_pkg::dispatch_t disp_woken;
  issue_pkg::dispatch_t sel_uop;

  // True when any valid writeback lane carries this tag
  function automatic logic tag_hit(input issue_pkg::preg_t tag,
                                   input issue_pkg::wb_t [WB_NUM-1:0] wb);
    logic hit;
    hit = 1'b0;
    for (int l = 0; l < WB_NUM; l++) begin
      if (wb[l].valid && wb[l].pdest == tag) begin
        hit = 1'b1;
      end
    end
    return hit;
  endfunction

  // Wrap bits equal: smaller index is older, otherwise larger index is older
  function automatic logic is_older(input logic a_age, input issue_pkg::rob_idx_t a_idx,
                                    input logic b_age, input issue_pkg::rob_idx_t b_idx);
    return (a_age == b_age) ? (a_idx < b_idx) : (a_idx > b_idx);
  endfunction

  // ========================================
  // Slot status and allocation
  // ========================================
  always_comb begin
    wr_idx = '0;
    for (int j = 0; j < BANK_SIZE; j++) begin
      free[j] = ~ent_q[j].valid | ent_q[j].issued;
      rdy[j]  = ent_q[j].valid & ~ent_q[j].issued &
                (ent_q[j].uop.psrc0_ready | ~ent_q[j].uop.psrc0_valid) &
                (ent_q[j].uop.psrc1_ready | ~ent_q[j].uop.psrc1_valid);
    end
    // Scan downward so the lowest free slot is the one left standing
    for (int j = BANK_SIZE - 1; j >= 0; j--) begin
      if (free[j]) begin
        wr_idx = SLOT_W'(j);
      end
    end
  end

  assign disp_ready_o = |free;

  // A source written back in the dispatch cycle arrives already awake
  always_comb begin
    disp_woken = disp_i;
    if (tag_hit(disp_i.psrc0, wb_i)) begin
      disp_woken.psrc0_ready = 1'b1;
    end
    if (tag_hit(disp_i.psrc1, wb_i)) begin
      disp_woken.psrc1_ready = 1'b1;
    end
  end

  // ========================================
  // Oldest-first select
  // ========================================
  always_comb begin
    sel_found = 1'b0;
    sel_idx   = '0;
    for (int j = 0; j < BANK_SIZE; j++) begin
      if (rdy[j]) begin
        if (!sel_found || is_older(ent_q[j].uop.age_bit, ent_q[j].uop.rob_idx,
                                   ent_q[sel_idx].uop.age_bit,
                                   ent_q[sel_idx].uop.rob_idx)) begin
          sel_found = 1'b1;
          sel_idx   = SLOT_W'(j);
        end
      end
    end
  end

  assign sel_uop     = ent_q[sel_idx].uop;
  assign iss_valid_o = sel_found;

  always_comb begin
    iss_o.op          = sel_uop.op;
    iss_o.rob_idx     = sel_uop.rob_idx;
    iss_o.pdest       = sel_uop.pdest;
    iss_o.psrc0       = sel_uop.psrc0;
    iss_o.psrc0_valid = sel_uop.psrc0_valid;
    iss_o.psrc1       = sel_uop.psrc1;
    iss_o.psrc1_valid = sel_uop.psrc1_valid;
  end

  // ========================================
  // Next state: wakeup, issue mark, dispatch write
  // ========================================
  always_comb begin
    ent_d = ent_q;
    for (int j = 0; j < BANK_SIZE; j++) begin
      if (ent_q[j].valid) begin
        if (tag_hit(ent_q[j].uop.psrc0, wb_i)) begin
          ent_d[j].uop.psrc0_ready = 1'b1;
        end
        if (tag_hit(ent_q[j].uop.psrc1, wb_i)) begin
          ent_d[j].uop.psrc1_ready = 1'b1;
        end
      end
    end
    if (iss_valid_o && iss_ready_i) begin
      ent_d[sel_idx].issued = 1'b1;
    end
    // Never the selected slot, since that one is not free yet
    if (disp_valid_i && disp_ready_o) begin
      ent_d[wr_idx].valid  = 1'b1;
      ent_d[wr_idx].issued = 1'b0;
      ent_d[wr_idx].uop    = disp_woken;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      ent_q <= '0;
    end else if (flush_i) begin
      ent_q <= '0;
    end else begin
      ent_q <= ent_d;
    end
  end

endmodule

//--- hdl/issue_alu.sv
// Single-cycle integer ALU behind one reservation-station bank.
// Ready follows the stall input. On an issue handshake the operands come
// from the register file and the result is registered, so the result and
// its writeback lane are valid for exactly one cycle after issue.
`timescale 1ns/10ps

module issue_alu (
  input  logic                          clk,
  input  logic                          rst_n,
  input  logic                          flush_i,
  input  logic                          fu_stall_i,
  input  logic                          iss_valid_i,
  input  issue_pkg::issue_t             iss_i,
  output logic                          iss_ready_o,
  output issue_pkg::preg_t [1:0]        rd_addr_o,
  input  issue_pkg::data_t [1:0]        rd_data_i,
  output issue_pkg::wb_t                wb_o,
  output logic                          res_valid_o,
  output issue_pkg::result_t            res_o
);

  logic               fire;
  issue_pkg::data_t   opnd_a;
  issue_pkg::data_t   opnd_b;
  issue_pkg::data_t   alu_out;
  logic               res_valid_q;
  issue_pkg::result_t res_q;

  assign iss_ready_o = ~fu_stall_i;
  assign fire        = iss_valid_i & iss_ready_o;

  assign rd_addr_o[0] = iss_i.psrc0;
  assign rd_addr_o[1] = iss_i.psrc1;

  // Unused sources read as zero
  assign opnd_a = iss_i.psrc0_valid ? rd_data_i[0] : '0;
  assign opnd_b = iss_i.psrc1_valid ? rd_data_i[1] : '0;

  always_comb begin
    case (iss_i.op)
      issue_pkg::OP_ADD: alu_out = opnd_a + opnd_b;
      issue_pkg::OP_SUB: alu_out = opnd_a - opnd_b;
      issue_pkg::OP_AND: alu_out = opnd_a & opnd_b;
      default:           alu_out = opnd_a ^ opnd_b;
    endcase
  end

  // Flush drops whatever issues in the same cycle
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      res_valid_q <= 1'b0;
    end else begin
      res_valid_q <= fire & ~flush_i;
    end
  end

  always_ff @(posedge clk) begin
    if (fire) begin
      res_q.rob_idx <= iss_i.rob_idx;
      res_q.pdest   <= iss_i.pdest;
      res_q.data    <= alu_out;
    end
  end

  assign res_valid_o = res_valid_q;
  assign res_o       = res_q;

  assign wb_o.valid = res_valid_q;
  assign wb_o.pdest = res_q.pdest;
  assign wb_o.data  = res_q.data;

endmodule

//--- hdl/issue_top.sv
// Top level of the issue subsystem.
// Each bank pairs with its own ALU; all ALUs share one register file.
// The wakeup bus carries one lane per ALU plus the external load lane,
// which sits on the highest lane so it wins register write collisions.
`timescale 1ns/10ps

module issue_top #(
  parameter int BANK_NUM  = 2,
  parameter int BANK_SIZE = 4
) (
  input  logic                                    clk,
  input  logic                                    rst_n,
  input  logic                                    flush_i,
  input  logic                 [BANK_NUM-1:0]     disp_valid_i,
  input  issue_pkg::dispatch_t [BANK_NUM-1:0]     disp_i,
  output logic                 [BANK_NUM-1:0]     disp_ready_o,
  input  issue_pkg::wb_t                          ext_wb_i,
  input  logic                 [BANK_NUM-1:0]     fu_stall_i,
  output logic                 [BANK_NUM-1:0]     res_valid_o,
  output issue_pkg::result_t   [BANK_NUM-1:0]     res_o
);

  localparam int WB_NUM = BANK_NUM + 1;

  issue_pkg::wb_t    [WB_NUM-1:0]         wb_bus;
  issue_pkg::wb_t    [BANK_NUM-1:0]       alu_wb;
  logic              [BANK_NUM-1:0]       iss_valid;
  logic              [BANK_NUM-1:0]       iss_ready;
  issue_pkg::issue_t [BANK_NUM-1:0]       iss;
  issue_pkg::preg_t  [BANK_NUM-1:0][1:0]  rd_addr;
  issue_pkg::data_t  [BANK_NUM-1:0][1:0]  rd_data;

  // ALU lanes low, external lane on top
  assign wb_bus = {ext_wb_i, alu_wb};

  // ========================================
  // Bank and ALU pairs
  // ========================================
  for (genvar b = 0; b < BANK_NUM; b++) begin : g_bank
    rs_bank #(
      .BANK_SIZE (BANK_SIZE),
      .WB_NUM    (WB_NUM)
    ) u_rs_bank (
      .clk          (clk),
      .rst_n        (rst_n),
      .flush_i      (flush_i),
      .disp_valid_i (disp_valid_i[b]),
      .disp_i       (disp_i[b]),
      .disp_ready_o (disp_ready_o[b]),
      .wb_i         (wb_bus),
      .iss_ready_i  (iss_ready[b]),
      .iss_valid_o  (iss_valid[b]),
      .iss_o        (iss[b])
    );

    issue_alu u_issue_alu (
      .clk         (clk),
      .rst_n       (rst_n),
      .flush_i     (flush_i),
      .fu_stall_i  (fu_stall_i[b]),
      .iss_valid_i (iss_valid[b]),
      .iss_i       (iss[b]),
      .iss_ready_o (iss_ready[b]),
      .rd_addr_o   (rd_addr[b]),
      .rd_data_i   (rd_data[b]),
      .wb_o        (alu_wb[b]),
      .res_valid_o (res_valid_o[b]),
      .res_o       (res_o[b])
    );
  end

  phys_regfile #(
    .BANK_NUM (BANK_NUM),
    .WB_NUM   (WB_NUM)
  ) u_phys_regfile (
    .clk       (clk),
    .rst_n     (rst_n),
    .wb_i      (wb_bus),
    .rd_addr_i (rd_addr),
    .rd_data_o (rd_data)
  );

endmodule

//--- verif/issue_tb.sv
// Directed testbench for the out-of-order issue subsystem.
// Keeps a mirror of the register file and checks every result against it.
// Covers basic issue, wakeup from both lane types, oldest-first select,
// back-pressure on a full bank and flush.
`timescale 1ns/10ps

module issue_tb;

  localparam int BANK_NUM    = 2;
  localparam int BANK_SIZE   = 4;
  localparam int NUM_TESTS   = 6;
  localparam int TEST_BUDGET = 200;

  logic                                        clk;
  logic                                        rst_n;
  logic                                        flush_i;
  logic                 [BANK_NUM-1:0]         disp_valid_i;
  issue_pkg::dispatch_t [BANK_NUM-1:0]         disp_i;
  logic                 [BANK_NUM-1:0]         disp_ready_o;
  issue_pkg::wb_t                              ext_wb_i;
  logic                 [BANK_NUM-1:0]         fu_stall_i;
  logic                 [BANK_NUM-1:0]         res_valid_o;
  issue_pkg::result_t   [BANK_NUM-1:0]         res_o;

  // Reference state
  issue_pkg::data_t     mirror [issue_pkg::PREG_NUM];
  logic                 busy   [issue_pkg::PREG_NUM];
  issue_pkg::dispatch_t tab    [issue_pkg::ROB_DEPTH];
  logic                 pend   [issue_pkg::ROB_DEPTH];
  int                   owner  [issue_pkg::ROB_DEPTH];
  int                   pend_cnt;
  issue_pkg::rob_idx_t  order_q [$];
  logic [31:0]          lfsr_q;

  issue_top #(
    .BANK_NUM  (BANK_NUM),
    .BANK_SIZE (BANK_SIZE)
  ) u_issue_top (
    .clk          (clk),
    .rst_n        (rst_n),
    .flush_i      (flush_i),
    .disp_valid_i (disp_valid_i),
    .disp_i       (disp_i),
    .disp_ready_o (disp_ready_o),
    .ext_wb_i     (ext_wb_i),
    .fu_stall_i   (fu_stall_i),
    .res_valid_o  (res_valid_o),
    .res_o        (res_o)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  initial begin
    repeat (NUM_TESTS * TEST_BUDGET) @(posedge clk);
    report_and_stop("Watchdog expired before all tests finished");
  end

  // ========================================
  // Reporting and compare tasks
  // ========================================
  task automatic report_and_stop(input string why);
    $display("%s", why);
    $display(">>> FAIL");
    $fatal(1, "simulation stopped on error");
  endtask

  task automatic check_result(input string name, input issue_pkg::result_t act,
                              input issue_pkg::result_t exp);
    if (act !== exp) begin
      report_and_stop($sformatf("[FAIL] t=%0t %s got %h expected %h", $time, name, act, exp));
    end
  endtask

  task automatic check_ready(input string name, input logic act, input logic exp);
    if (act !== exp) begin
      report_and_stop($sformatf("[FAIL] t=%0t %s got %b expected %b", $time, name, act, exp));
    end
  endtask

  task automatic check_rob(input string name, input issue_pkg::rob_idx_t act,
                           input issue_pkg::rob_idx_t exp);
    if (act !== exp) begin
      report_and_stop($sformatf("[FAIL] t=%0t %s got %0d expected %0d", $time, name, act, exp));
    end
  endtask

  // ========================================
  // Reference model and stimulus helpers
  // ========================================
  // Fibonacci LFSR, taps 32 22 2 1
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    logic        fb;
    r = '0;
    for (int i = 0; i < n; i++) begin
      fb     = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
      lfsr_q = {lfsr_q[30:0], fb};
      r      = {r[30:0], fb};
    end
    return r;
  endfunction

  function automatic issue_pkg::data_t expect_alu(input issue_pkg::alu_op_t op,
                                                  input issue_pkg::data_t a,
                                                  input issue_pkg::data_t b);
    if (op == issue_pkg::OP_ADD) return a + b;
    else if (op == issue_pkg::OP_SUB) return a - b;
    else if (op == issue_pkg::OP_AND) return a & b;
    else return a ^ b;
  endfunction

  // Unused sources count as zero
  function automatic issue_pkg::data_t src_val(input issue_pkg::preg_t s, input logic v);
    return v ? mirror[s] : '0;
  endfunction

  function automatic issue_pkg::dispatch_t make_uop(input issue_pkg::alu_op_t op,
      input issue_pkg::rob_idx_t rob, input logic age, input issue_pkg::preg_t dst,
      input issue_pkg::preg_t s0, input issue_pkg::preg_t s1);
    issue_pkg::dispatch_t u;
    u             = '0;
    u.op          = op;
    u.rob_idx     = rob;
    u.age_bit     = age;
    u.pdest       = dst;
    u.psrc0       = s0;
    u.psrc0_valid = 1'b1;
    u.psrc1       = s1;
    u.psrc1_valid = 1'b1;
    return u;
  endfunction

  task automatic score_result(input int bank, input issue_pkg::result_t r);
    issue_pkg::dispatch_t u;
    issue_pkg::result_t   exp;
    if (!pend[r.rob_idx]) begin
      report_and_stop($sformatf("Result for ROB index %0d that is not in flight", r.rob_idx));
    end
    if (owner[r.rob_idx] != bank) begin
      report_and_stop($sformatf("Result for ROB index %0d came out of bank %0d, not bank %0d",
                                r.rob_idx, bank, owner[r.rob_idx]));
    end
    u           = tab[r.rob_idx];
    exp.rob_idx = r.rob_idx;
    exp.pdest   = u.pdest;
    exp.data    = expect_alu(u.op, src_val(u.psrc0, u.psrc0_valid),
                             src_val(u.psrc1, u.psrc1_valid));
    check_result("res_o", r, exp);
    mirror[u.pdest] = r.data;
    busy[u.pdest]   = 1'b0;
    pend[r.rob_idx] = 1'b0;
    pend_cnt--;
    order_q.push_back(r.rob_idx);
  endtask

  task automatic watch_results();
    forever begin
      @(negedge clk);
      if (rst_n) begin
        for (int b = 0; b < BANK_NUM; b++) begin
          if (res_valid_o[b]) score_result(b, res_o[b]);
        end
      end
    end
  endtask

  // Ready bits follow the busy table, refreshed every cycle the dispatch waits
  task automatic send(input logic bank, input issue_pkg::dispatch_t u);
    int   waited;
    logic acc;
    waited = 0;
    acc    = 1'b0;
    while (!acc) begin
      @(posedge clk);
      u.psrc0_ready = !busy[u.psrc0];
      u.psrc1_ready = !busy[u.psrc1];
      disp_valid_i[bank] <= 1'b1;
      disp_i[bank]       <= u;
      @(negedge clk);
      acc = disp_ready_o[bank];
      waited++;
      if (waited > 40) report_and_stop("Dispatch was never accepted by the bank");
    end
    tab[u.rob_idx]   = u;
    pend[u.rob_idx]  = 1'b1;
    owner[u.rob_idx] = bank;
    busy[u.pdest]    = 1'b1;
    pend_cnt++;
    @(posedge clk);
    disp_valid_i[bank] <= 1'b0;
  endtask

  task automatic ext_write(input issue_pkg::preg_t tag, input issue_pkg::data_t val);
    issue_pkg::wb_t w;
    w.valid = 1'b1;
    w.pdest = tag;
    w.data  = val;
    @(posedge clk);
    ext_wb_i <= w;
    mirror[tag] = val;
    busy[tag]   = 1'b0;
    @(posedge clk);
    w.valid = 1'b0;
    ext_wb_i <= w;
  endtask

  task automatic set_stall(input logic [BANK_NUM-1:0] s);
    @(posedge clk);
    fu_stall_i <= s;
  endtask

  task automatic wait_drain();
    int n;
    n = 0;
    while (pend_cnt != 0) begin
      @(negedge clk);
      n++;
      if (n > 60) report_and_stop("Dispatched ops never produced their results");
    end
    @(posedge clk);
  endtask

  // ========================================
  // Directed tests
  // ========================================
  task automatic test_basic_issue();
    issue_pkg::dispatch_t u;
    @(negedge clk);
    check_ready("disp_ready_o[0]", disp_ready_o[0], 1'b1);
    check_ready("disp_ready_o[1]", disp_ready_o[1], 1'b1);
    check_ready("res_valid_o[0]", res_valid_o[0], 1'b0);
    check_ready("res_valid_o[1]", res_valid_o[1], 1'b0);
    for (int i = 1; i <= 8; i++) begin
      ext_write(issue_pkg::preg_t'(i), rand_bits(32));
    end
    send(1'b0, make_uop(issue_pkg::OP_ADD, 4'd0, 1'b0, 5'd20, 5'd1, 5'd2));
    // Second source unused, so it reads as zero
    u = make_uop(issue_pkg::OP_SUB, 4'd1, 1'b0, 5'd21, 5'd3, 5'd4);
    u.psrc1_valid = 1'b0;
    send(1'b1, u);
    wait_drain();
  endtask

  task automatic test_ext_wakeup();
    busy[9] = 1'b1;
    send(1'b0, make_uop(issue_pkg::OP_XOR, 4'd2, 1'b0, 5'd22, 5'd9, 5'd3));
    repeat (6) begin
      @(negedge clk);
      check_ready("res_valid_o[0]", res_valid_o[0], 1'b0);
    end
    ext_write(5'd9, rand_bits(32));
    wait_drain();
  endtask

  task automatic test_dep_chain();
    issue_pkg::preg_t s0;
    issue_pkg::preg_t s1;
    issue_pkg::alu_op_t op;
    for (int i = 0; i < 8; i++) begin
      s0 = (i == 0) ? 5'd1 : issue_pkg::preg_t'(9 + i);
      s1 = issue_pkg::preg_t'(1 + rand_bits(3));
      op = issue_pkg::alu_op_t'(rand_bits(2));
      send(i[0], make_uop(op, issue_pkg::rob_idx_t'(3 + i), 1'b0,
                          issue_pkg::preg_t'(10 + i), s0, s1));
    end
    wait_drain();
  endtask

  task automatic test_oldest_first();
    set_stall(2'b01);
    // Wrapped entries (age bit 1) are younger than 12 and 14
    send(1'b0, make_uop(issue_pkg::OP_ADD, 4'd2,  1'b1, 5'd23, 5'd1, 5'd2));
    send(1'b0, make_uop(issue_pkg::OP_SUB, 4'd14, 1'b0, 5'd24, 5'd3, 5'd4));
    send(1'b0, make_uop(issue_pkg::OP_AND, 4'd0,  1'b1, 5'd25, 5'd5, 5'd6));
    send(1'b0, make_uop(issue_pkg::OP_XOR, 4'd12, 1'b0, 5'd26, 5'd7, 5'd8));
    order_q.delete();
    set_stall(2'b00);
    wait_drain();
    check_rob("issue order 0", order_q[0], 4'd12);
    check_rob("issue order 1", order_q[1], 4'd14);
    check_rob("issue order 2", order_q[2], 4'd0);
    check_rob("issue order 3", order_q[3], 4'd2);
  endtask

  task automatic test_full_bank();
    set_stall(2'b10);
    for (int i = 0; i < BANK_SIZE; i++) begin
      send(1'b1, make_uop(issue_pkg::OP_ADD, issue_pkg::rob_idx_t'(4 + i), 1'b0,
                          issue_pkg::preg_t'(24 + i), 5'd1, 5'd2));
    end
    @(negedge clk);
    check_ready("disp_ready_o[1]", disp_ready_o[1], 1'b0);
    // Fifth op waits on a full bank until the stall lifts
    fork
      send(1'b1, make_uop(issue_pkg::OP_SUB, 4'd8, 1'b0, 5'd28, 5'd5, 5'd6));
      begin
        repeat (4) @(posedge clk);
        fu_stall_i <= 2'b00;
      end
    join
    wait_drain();
  endtask

  task automatic test_flush();
    set_stall(2'b11);
    // Bank 0 filled up so its ready is low going into the flush
    for (int i = 0; i < BANK_SIZE; i++) begin
      send(1'b0, make_uop(issue_pkg::OP_ADD, issue_pkg::rob_idx_t'(9 + i), 1'b0,
                          issue_pkg::preg_t'(28 + i), 5'd1, 5'd2));
    end
    send(1'b1, make_uop(issue_pkg::OP_XOR, 4'd13, 1'b0, 5'd27, 5'd5, 5'd6));
    @(negedge clk);
    check_ready("disp_ready_o[0]", disp_ready_o[0], 1'b0);
    @(posedge clk);
    flush_i <= 1'b1;
    @(posedge clk);
    flush_i <= 1'b0;
    // Flushed ops never complete, so any later result is a failure
    for (int i = 0; i < issue_pkg::ROB_DEPTH; i++) pend[i] = 1'b0;
    for (int i = 0; i < issue_pkg::PREG_NUM; i++) busy[i] = 1'b0;
    pend_cnt = 0;
    set_stall(2'b00);
    repeat (8) begin
      @(negedge clk);
      check_ready("res_valid_o[0]", res_valid_o[0], 1'b0);
      check_ready("res_valid_o[1]", res_valid_o[1], 1'b0);
    end
    check_ready("disp_ready_o[0]", disp_ready_o[0], 1'b1);
    check_ready("disp_ready_o[1]", disp_ready_o[1], 1'b1);
  endtask

  // ========================================
  // Main sequence
  // ========================================
  initial begin
    rst_n        <= 1'b0;
    flush_i      <= 1'b0;
    disp_valid_i <= '0;
    disp_i       <= '0;
    ext_wb_i     <= '0;
    fu_stall_i   <= '0;
    lfsr_q   = 32'h75df_6490;
    pend_cnt = 0;
    for (int i = 0; i < issue_pkg::PREG_NUM; i++) begin
      mirror[i] = '0;
      busy[i]   = 1'b0;
    end
    for (int i = 0; i < issue_pkg::ROB_DEPTH; i++) begin
      pend[i]  = 1'b0;
      owner[i] = 0;
    end
    repeat (5) @(posedge clk);
    rst_n <= 1'b1;
    fork
      watch_results();
    join_none
    test_basic_issue();
    test_ext_wakeup();
    test_dep_chain();
    test_oldest_first();
    test_full_bank();
    test_flush();
    $display(">>> PASS");
    $finish;
  end

endmodule

//--- sim.f
hdl/issue_pkg.sv
hdl/phys_regfile.sv
hdl/rs_bank.sv
hdl/issue_alu.sv
hdl/issue_top.sv
verif/issue_tb.sv

//--- run.sh
#!/bin/sh
# Builds the issue subsystem testbench with Verilator and runs it.
set -e
cd "$(dirname "$0")"
rm -rf obj_dir
verilator --binary --timing -f sim.f --top-module issue_tb -o Vissue_tb
./obj_dir/Vissue_tb | tee sim.log
if grep -q ">>> FAIL" sim.log; then
  echo "Simulation failed"
  exit 1
fi
if ! grep -q ">>> PASS" sim.log; then
  echo "Simulation ended without a result"
  exit 1
fi
echo "Simulation passed"
